// File: src/board_cfg_pkg.sv
package board_cfg_pkg;

	// Status word from the I/O controller
	localparam int status_w = 32;

	localparam int st_reset      = 0; // OSD reset request
	localparam int st_rotate     = 2; // 0 rotates the controls
	localparam int st_reset_menu = 6; // Reset entry in the menu

	// DIP sources with 2-bit lives and bonus fields
	localparam int st_lives_lo = 8;
	localparam int st_bonus_lo = 10;
	localparam int st_cabinet  = 12; // Upright when set

	localparam int dip_w = 8;

	// 3-3-2 core colour widened to 6-bit VGA pins
	localparam int core_color_w = 3;
	localparam int vga_color_w  = 6;

	localparam int audio_w = 8; // Sound sample width

endpackage

// File: src/ctrl_pkg.sv
package ctrl_pkg;

	// PS/2 set 2 scan codes
	localparam logic [7:0] key_up     = 8'h75;
	localparam logic [7:0] key_down   = 8'h72;
	localparam logic [7:0] key_left   = 8'h6B;
	localparam logic [7:0] key_right  = 8'h74;
	localparam logic [7:0] key_coin   = 8'h76; // ESC
	localparam logic [7:0] key_start1 = 8'h05; // F1
	localparam logic [7:0] key_start2 = 8'h06; // F2
	localparam logic [7:0] key_fire   = 8'h29; // Space

	// Joystick byte layout
	localparam int joy_right = 0;
	localparam int joy_left  = 1;
	localparam int joy_down  = 2;
	localparam int joy_up    = 3;
	localparam int joy_fire  = 4;

	// Held button vector
	localparam int btn_w      = 8;
	localparam int btn_up     = 0;
	localparam int btn_down   = 1;
	localparam int btn_left   = 2;
	localparam int btn_right  = 3;
	localparam int btn_fire   = 4;
	localparam int btn_coin   = 5;
	localparam int btn_start1 = 6;
	localparam int btn_start2 = 7;

endpackage

// File: src/key_latch.sv
`timescale 1ns/1ps

module key_latch (
	input  logic                      clock_24,
	input  logic                      rst_n,
	input  logic                      key_strobe,
	input  logic                      key_pressed,
	input  logic [7:0]                key_code,
	output logic [ctrl_pkg::btn_w-1:0] held
);

	always_ff @(posedge clock_24 or negedge rst_n) begin
		if (!rst_n) begin
			held <= '0;
		end else if (key_strobe) begin
			case (key_code)
				ctrl_pkg::key_up: begin
					held[ctrl_pkg::btn_up] <= key_pressed;
				end
				ctrl_pkg::key_down: begin
					held[ctrl_pkg::btn_down] <= key_pressed;
				end
				ctrl_pkg::key_left: begin
					held[ctrl_pkg::btn_left] <= key_pressed;
				end
				ctrl_pkg::key_right: begin
					held[ctrl_pkg::btn_right] <= key_pressed;
				end
				ctrl_pkg::key_fire: begin
					held[ctrl_pkg::btn_fire] <= key_pressed;
				end
				ctrl_pkg::key_coin: begin
					held[ctrl_pkg::btn_coin] <= key_pressed;
				end
				ctrl_pkg::key_start1: begin
					held[ctrl_pkg::btn_start1] <= key_pressed;
				end
				ctrl_pkg::key_start2: begin
					held[ctrl_pkg::btn_start2] <= key_pressed;
				end
				default: begin
					held <= held; // Other keys ignored
				end
			endcase
		end
	end

endmodule

// File: src/control_mapper.sv
`timescale 1ns/1ps

module control_mapper (
	input  logic                              clock_24,
	input  logic                              rst_n,
	input  logic [ctrl_pkg::btn_w-1:0]        held,
	input  logic [7:0]                        joystick_0,
	input  logic [7:0]                        joystick_1,
	input  logic [board_cfg_pkg::status_w-1:0] status,
	input  logic                              menu_reset,
	output logic                              up_n,
	output logic                              down_n,
	output logic                              left_n,
	output logic                              right_n,
	output logic                              fire_n,
	output logic                              coin_n,
	output logic                              start1_n,
	output logic                              start2_n,
	output logic [board_cfg_pkg::dip_w-1:0]    dip_sw,
	output logic                              core_rst_n
);

	logic src_up, src_down, src_left, src_right, src_fire;
	logic rotate;
	logic m_up, m_down, m_left, m_right;

	assign src_up    = held[ctrl_pkg::btn_up] | joystick_0[ctrl_pkg::joy_up] |
			   joystick_1[ctrl_pkg::joy_up];
	assign src_down  = held[ctrl_pkg::btn_down] | joystick_0[ctrl_pkg::joy_down] |
			   joystick_1[ctrl_pkg::joy_down];
	assign src_left  = held[ctrl_pkg::btn_left] | joystick_0[ctrl_pkg::joy_left] |
			   joystick_1[ctrl_pkg::joy_left];
	assign src_right = held[ctrl_pkg::btn_right] | joystick_0[ctrl_pkg::joy_right] |
			   joystick_1[ctrl_pkg::joy_right];
	assign src_fire  = held[ctrl_pkg::btn_fire] | joystick_0[ctrl_pkg::joy_fire] |
			   joystick_1[ctrl_pkg::joy_fire];

	assign rotate  = ~status[board_cfg_pkg::st_rotate]; // Vertical monitor mode
	assign m_up    = rotate ? src_left  : src_up;
	assign m_down  = rotate ? src_right : src_down;
	assign m_left  = rotate ? src_down  : src_left;
	assign m_right = rotate ? src_up    : src_right;

	always_ff @(posedge clock_24 or negedge rst_n) begin
		if (!rst_n) begin
			{up_n, down_n, left_n, right_n} <= 4'hf;
			{fire_n, coin_n, start1_n, start2_n} <= 4'hf;
			dip_sw     <= '0;
			core_rst_n <= 1'b0; // Core held until first clock
		end else begin
			up_n     <= ~m_up;
			down_n   <= ~m_down;
			left_n   <= ~m_left;
			right_n  <= ~m_right;
			fire_n   <= ~src_fire;
			coin_n   <= ~held[ctrl_pkg::btn_coin];
			start1_n <= ~held[ctrl_pkg::btn_start1];
			start2_n <= ~held[ctrl_pkg::btn_start2];
			dip_sw   <= {~status[board_cfg_pkg::st_cabinet], 3'b000,
				     status[board_cfg_pkg::st_bonus_lo+1 -: 2],
				     status[board_cfg_pkg::st_lives_lo+1 -: 2]};
			core_rst_n <= ~(status[board_cfg_pkg::st_reset] |
					status[board_cfg_pkg::st_reset_menu] | menu_reset);
		end
	end

endmodule

// File: src/video_gate.sv
`timescale 1ns/1ps

module video_gate #(
	parameter int COLOR_DEPTH = 3
) (
	input  logic                                   clock_24,
	input  logic                                   rst_n,
	input  logic [COLOR_DEPTH-1:0]                 r_in,
	input  logic [COLOR_DEPTH-1:0]                 g_in,
	input  logic [COLOR_DEPTH-2:0]                 b_in,
	input  logic                                   vblank,
	input  logic                                   hs_n_in,
	input  logic                                   vs_n_in,
	output logic [board_cfg_pkg::vga_color_w-1:0]  vga_r,
	output logic [board_cfg_pkg::vga_color_w-1:0]  vga_g,
	output logic [board_cfg_pkg::vga_color_w-1:0]  vga_b,
	output logic                                   vga_hs,
	output logic                                   vga_vs
);

	// Repeat the colour from its MSB down until the pin width is filled
	function automatic logic [board_cfg_pkg::vga_color_w-1:0] expand(
		input logic [COLOR_DEPTH-1:0] c
	);
		logic [board_cfg_pkg::vga_color_w-1:0] res;
		for (int i = 0; i < board_cfg_pkg::vga_color_w; i++) begin
			res[board_cfg_pkg::vga_color_w-1-i] = c[COLOR_DEPTH-1-(i % COLOR_DEPTH)];
		end
		return res;
	endfunction

	logic [COLOR_DEPTH-1:0] b_wide;

	assign b_wide = {b_in[COLOR_DEPTH-2], b_in}; // 2-bit blue to 3 bits

	always_ff @(posedge clock_24 or negedge rst_n) begin
		if (!rst_n) begin
			vga_r  <= '0;
			vga_g  <= '0;
			vga_b  <= '0;
			vga_hs <= 1'b1;
			vga_vs <= 1'b1;
		end else begin
			vga_r  <= vblank ? '0 : expand(r_in);
			vga_g  <= vblank ? '0 : expand(g_in);
			vga_b  <= vblank ? '0 : expand(b_wide);
			vga_hs <= hs_n_in; // Same stage as colour
			vga_vs <= vs_n_in;
		end
	end

endmodule

// File: src/sigma_delta_dac.sv
`timescale 1ns/1ps

module sigma_delta_dac #(
	parameter int DAC_BITS = board_cfg_pkg::audio_w
) (
	input  logic                clock_24,
	input  logic                rst_n,
	input  logic [DAC_BITS-1:0] sample,
	output logic                dac_out
);

	logic [DAC_BITS-1:0] acc;
	logic [DAC_BITS:0]   sum;

	// Carry out sets the pulse density
	assign sum = {1'b0, acc} + {1'b0, sample};

	always_ff @(posedge clock_24 or negedge rst_n) begin
		if (!rst_n) begin
			acc     <= '0;
			dac_out <= 1'b0;
		end else begin
			acc     <= sum[DAC_BITS-1:0];
			dac_out <= sum[DAC_BITS];
		end
	end

endmodule

// File: src/cabinet_io.sv
`timescale 1ns/1ps

module cabinet_io (
	input  logic                                    clock_24,
	input  logic                                    rst_n,
	input  logic                                    key_strobe,
	input  logic                                    key_pressed,
	input  logic [7:0]                              key_code,
	input  logic [7:0]                              joystick_0,
	input  logic [7:0]                              joystick_1,
	input  logic [board_cfg_pkg::status_w-1:0]      status,
	input  logic                                    menu_reset,
	input  logic [board_cfg_pkg::core_color_w-1:0]  r_in,
	input  logic [board_cfg_pkg::core_color_w-1:0]  g_in,
	input  logic [board_cfg_pkg::core_color_w-2:0]  b_in,
	input  logic                                    vblank,
	input  logic                                    hs_n_in,
	input  logic                                    vs_n_in,
	input  logic [board_cfg_pkg::audio_w-1:0]       sample,
	output logic                                    up_n,
	output logic                                    down_n,
	output logic                                    left_n,
	output logic                                    right_n,
	output logic                                    fire_n,
	output logic                                    coin_n,
	output logic                                    start1_n,
	output logic                                    start2_n,
	output logic [board_cfg_pkg::dip_w-1:0]         dip_sw,
	output logic                                    core_rst_n,
	output logic [board_cfg_pkg::vga_color_w-1:0]   vga_r,
	output logic [board_cfg_pkg::vga_color_w-1:0]   vga_g,
	output logic [board_cfg_pkg::vga_color_w-1:0]   vga_b,
	output logic                                    vga_hs,
	output logic                                    vga_vs,
	output logic                                    audio_l,
	output logic                                    audio_r
);

	logic [ctrl_pkg::btn_w-1:0] held;

	key_latch key_latch_inst (
		.clock_24, .rst_n, .key_strobe, .key_pressed, .key_code, .held
	);

	control_mapper control_mapper_inst (
		.clock_24, .rst_n, .held, .joystick_0, .joystick_1, .status, .menu_reset,
		.up_n, .down_n, .left_n, .right_n, .fire_n, .coin_n, .start1_n, .start2_n,
		.dip_sw, .core_rst_n
	);

	video_gate #(.COLOR_DEPTH(board_cfg_pkg::core_color_w)) video_gate_inst (
		.clock_24, .rst_n, .r_in, .g_in, .b_in, .vblank, .hs_n_in, .vs_n_in,
		.vga_r, .vga_g, .vga_b, .vga_hs, .vga_vs
	);

	sigma_delta_dac #(.DAC_BITS(board_cfg_pkg::audio_w)) sigma_delta_dac_inst (
		.clock_24, .rst_n, .sample,
		.dac_out (audio_l)
	);

	assign audio_r = audio_l; // Mono to both pins

endmodule

// File: verif/cabinet_io_assert.sv
`timescale 1ns/1ps

module cabinet_io_assert (
	input logic                                   clock_24,
	input logic                                   rst_n,
	input logic                                   vblank,
	input logic [board_cfg_pkg::vga_color_w-1:0]  vga_r,
	input logic [board_cfg_pkg::vga_color_w-1:0]  vga_g,
	input logic [board_cfg_pkg::vga_color_w-1:0]  vga_b,
	input logic                                   vga_hs,
	input logic                                   vga_vs,
	input logic                                   audio_l,
	input logic                                   audio_r
);

	// Syncs idle high during reset
	syncs_high_in_reset: assert property (@(posedge clock_24)
		!rst_n |-> (vga_hs && vga_vs))
		else $error("VGA syncs low while in reset");

	audio_pins_equal: assert property (@(posedge clock_24) audio_r == audio_l)
		else $error("audio_r differs from audio_l");

	// Colour registered in the vblank cycle must be black
	blank_colours_zero: assert property (@(posedge clock_24) disable iff (!rst_n)
		$past(vblank) |-> (vga_r == '0 && vga_g == '0 && vga_b == '0))
		else $error("VGA colour not zero during vblank");

endmodule

// File: verif/tb_cabinet_io.sv
`timescale 1ns/1ps

module tb_cabinet_io;

	typedef struct {
		string       name;
		logic        strobe;
		logic        pressed;
		logic [7:0]  code;
		logic [7:0]  joy0;
		logic [7:0]  joy1;
		logic [31:0] status_v;
		logic        menu_rst;
		logic [2:0]  r;
		logic [2:0]  g;
		logic [1:0]  b;
		logic        blank;
		logic        hs;
		logic        vs;
		logic [7:0]  exp_ctrl;
		logic [7:0]  exp_dip;
		logic        exp_rst_n;
		logic [19:0] exp_video;
	} row_t;

	localparam logic [7:0] key_codes [8] = '{ctrl_pkg::key_up, ctrl_pkg::key_down,
		ctrl_pkg::key_left, ctrl_pkg::key_right, ctrl_pkg::key_fire, ctrl_pkg::key_coin,
		ctrl_pkg::key_start1, ctrl_pkg::key_start2};
	localparam int dir_bits [4] = '{ctrl_pkg::joy_up, ctrl_pkg::joy_down,
		ctrl_pkg::joy_left, ctrl_pkg::joy_right};

	logic clock_24, rst_n, key_strobe, key_pressed, menu_reset, vblank, hs_n_in, vs_n_in;
	logic [7:0] key_code, joystick_0, joystick_1, sample;
	logic [31:0] status;
	logic [2:0] r_in, g_in;
	logic [1:0] b_in;
	logic up_n, down_n, left_n, right_n, fire_n, coin_n, start1_n, start2_n;
	logic [7:0] dip_sw;
	logic core_rst_n, vga_hs, vga_vs, audio_l, audio_r;
	logic [5:0] vga_r, vga_g, vga_b;

	row_t rows[$];
	logic [7:0] model_held = '0; // Expected held keys while the table is built
	logic [31:0] rng_state = 32'hdba1_72d3;
	logic table_ready = 1'b0;
	int error_count = 0;

	cabinet_io cabinet_io_inst (.*);

	bind cabinet_io cabinet_io_assert cabinet_io_assert_inst (
		.clock_24(clock_24), .rst_n(rst_n), .vblank(vblank), .vga_r(vga_r), .vga_g(vga_g),
		.vga_b(vga_b), .vga_hs(vga_hs), .vga_vs(vga_vs), .audio_l(audio_l), .audio_r(audio_r)
	);

	always #5 clock_24 = ~clock_24;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	task automatic check_val(input string name, input string what, input logic [31:0] exp,
		input logic [31:0] act);
		assert (exp === act) else begin
			$display("MISMATCH %s %s expected %0h actual %0h", name, what, exp, act);
			error_count++;
		end
	endtask

	// Expected outputs follow the key, rotation, DIP and colour rules
	task automatic add_row(input string name, input logic strobe, input logic pressed,
		input logic [7:0] code, input logic [7:0] joy0, input logic [7:0] joy1,
		input logic [31:0] status_v, input logic menu_rst, input logic [2:0] r,
		input logic [2:0] g, input logic [1:0] b, input logic blank, input logic hs,
		input logic vs);
		row_t row;
		logic up_s, down_s, left_s, right_s, fire_s;
		logic [5:0] er, eg, eb;
		if (strobe) begin
			case (code)
				ctrl_pkg::key_up:     model_held[ctrl_pkg::btn_up] = pressed;
				ctrl_pkg::key_down:   model_held[ctrl_pkg::btn_down] = pressed;
				ctrl_pkg::key_left:   model_held[ctrl_pkg::btn_left] = pressed;
				ctrl_pkg::key_right:  model_held[ctrl_pkg::btn_right] = pressed;
				ctrl_pkg::key_fire:   model_held[ctrl_pkg::btn_fire] = pressed;
				ctrl_pkg::key_coin:   model_held[ctrl_pkg::btn_coin] = pressed;
				ctrl_pkg::key_start1: model_held[ctrl_pkg::btn_start1] = pressed;
				ctrl_pkg::key_start2: model_held[ctrl_pkg::btn_start2] = pressed;
				default: ;
			endcase
		end
		up_s    = model_held[ctrl_pkg::btn_up] | joy0[ctrl_pkg::joy_up] | joy1[ctrl_pkg::joy_up];
		down_s  = model_held[ctrl_pkg::btn_down] | joy0[ctrl_pkg::joy_down] |
			joy1[ctrl_pkg::joy_down];
		left_s  = model_held[ctrl_pkg::btn_left] | joy0[ctrl_pkg::joy_left] |
			joy1[ctrl_pkg::joy_left];
		right_s = model_held[ctrl_pkg::btn_right] | joy0[ctrl_pkg::joy_right] |
			joy1[ctrl_pkg::joy_right];
		fire_s  = model_held[ctrl_pkg::btn_fire] | joy0[ctrl_pkg::joy_fire] |
			joy1[ctrl_pkg::joy_fire];
		if (!status_v[board_cfg_pkg::st_rotate]) begin
			{up_s, down_s, left_s, right_s} = {left_s, right_s, down_s, up_s}; // Rotated
		end
		row.exp_ctrl = ~{up_s, down_s, left_s, right_s, fire_s, model_held[ctrl_pkg::btn_coin],
			model_held[ctrl_pkg::btn_start1], model_held[ctrl_pkg::btn_start2]};
		row.exp_dip = {~status_v[board_cfg_pkg::st_cabinet], 3'b000,
			status_v[board_cfg_pkg::st_bonus_lo +: 2], status_v[board_cfg_pkg::st_lives_lo +: 2]};
		row.exp_rst_n = ~(status_v[board_cfg_pkg::st_reset] |
			status_v[board_cfg_pkg::st_reset_menu] | menu_rst);
		er = blank ? 6'h00 : {r, r};
		eg = blank ? 6'h00 : {g, g};
		eb = blank ? 6'h00 : {b[1], b, b[1], b}; // Blue widened by its top bit
		row.exp_video = {er, eg, eb, hs, vs};
		row.name = name;
		row.strobe = strobe;
		row.pressed = pressed;
		row.code = code;
		row.joy0 = joy0;
		row.joy1 = joy1;
		row.status_v = status_v;
		row.menu_rst = menu_rst;
		row.r = r;
		row.g = g;
		row.b = b;
		row.blank = blank;
		row.hs = hs;
		row.vs = vs;
		rows.push_back(row);
	endtask

	// Entered 1 ns after a rising edge
	task automatic apply_row(input row_t row);
		key_strobe = row.strobe;
		key_pressed = row.pressed;
		key_code = row.code;
		joystick_0 = row.joy0;
		joystick_1 = row.joy1;
		status = row.status_v;
		menu_reset = row.menu_rst;
		r_in = row.r;
		g_in = row.g;
		b_in = row.b;
		vblank = row.blank;
		hs_n_in = row.hs;
		vs_n_in = row.vs;
		@(posedge clock_24);
		#1;
		key_strobe = 1'b0; // One strobe per event
		check_val(row.name, "dip_sw", 32'(row.exp_dip), 32'(dip_sw));
		check_val(row.name, "core_rst_n", 32'(row.exp_rst_n), 32'(core_rst_n));
		check_val(row.name, "video", 32'(row.exp_video),
			32'({vga_r, vga_g, vga_b, vga_hs, vga_vs}));
		@(posedge clock_24);
		#1;
		check_val(row.name, "controls", 32'(row.exp_ctrl), 32'({up_n, down_n, left_n, right_n,
			fire_n, coin_n, start1_n, start2_n}));
	endtask

	task automatic measure_audio(input logic [7:0] value);
		int count;
		count = 0;
		sample = value;
		repeat (256) begin
			@(posedge clock_24);
			#1;
			if (audio_l) count++;
			assert (audio_r === audio_l) else begin
				$display("audio_r differs from audio_l while sample is %0d", value);
				error_count++;
			end
		end
		check_val($sformatf("audio_%0d", value), "high_count", 32'(value), 32'(count));
	endtask

	initial begin
		logic [31:0] rv1, rv2, rv3;
		{clock_24, key_strobe, key_pressed, menu_reset, vblank} = '0;
		{hs_n_in, vs_n_in, rst_n} = 3'b111;
		{key_code, joystick_0, joystick_1, sample, status} = '0;
		{r_in, g_in, b_in} = '0;

		add_row("fire_press", 1'b1, 1'b1, ctrl_pkg::key_fire, 8'h00, 8'h00, 32'h4, 1'b0,
			3'd0, 3'd0, 2'd0, 1'b0, 1'b1, 1'b1);
		add_row("unknown_key", 1'b1, 1'b1, 8'h1c, 8'h00, 8'h00, 32'h4, 1'b0,
			3'd0, 3'd0, 2'd0, 1'b0, 1'b1, 1'b1);
		add_row("fire_release", 1'b1, 1'b0, ctrl_pkg::key_fire, 8'h00, 8'h00, 32'h4, 1'b0,
			3'd0, 3'd0, 2'd0, 1'b0, 1'b1, 1'b1);
		for (int k = 0; k < 8; k++) begin
			add_row($sformatf("key_%02h_press", key_codes[k]), 1'b1, 1'b1, key_codes[k],
				8'h00, 8'h00, 32'h4, 1'b0, 3'd0, 3'd0, 2'd0, 1'b0, 1'b1, 1'b1);
			add_row($sformatf("key_%02h_release", key_codes[k]), 1'b1, 1'b0, key_codes[k],
				8'h00, 8'h00, 32'h4, 1'b0, 3'd0, 3'd0, 2'd0, 1'b0, 1'b1, 1'b1);
		end
		for (int j = 0; j < 2; j++) begin
			for (int d = 0; d < 4; d++) begin
				for (int rot = 0; rot < 2; rot++) begin
					add_row($sformatf("joy%0d_bit%0d_rot%0d", j, dir_bits[d], rot), 1'b0, 1'b0,
						8'h00, j == 0 ? 8'(1 << dir_bits[d]) : 8'h00,
						j == 1 ? 8'(1 << dir_bits[d]) : 8'h00, rot != 0 ? 32'h0 : 32'h4,
						1'b0, 3'd0, 3'd0, 2'd0, 1'b0, 1'b1, 1'b1);
				end
			end
		end
		add_row("menu_reset_only", 1'b0, 1'b0, 8'h00, 8'h00, 8'h00, 32'h4, 1'b1,
			3'd0, 3'd0, 2'd0, 1'b0, 1'b1, 1'b1);
		add_row("video_white", 1'b0, 1'b0, 8'h00, 8'h00, 8'h00, 32'h4, 1'b0,
			3'd7, 3'd7, 2'd3, 1'b0, 1'b0, 1'b1);
		add_row("video_blank", 1'b0, 1'b0, 8'h00, 8'h00, 8'h00, 32'h4, 1'b0,
			3'd5, 3'd6, 2'd2, 1'b1, 1'b1, 1'b0);
		for (int n = 0; n < 24; n++) begin
			rv1 = next_rand();
			rv2 = next_rand();
			rv3 = next_rand();
			add_row($sformatf("random_%0d", n), 1'b0, 1'b0, 8'h00, rv1[7:0], rv1[15:8], rv2,
				1'b0, rv3[2:0], rv3[5:3], rv3[7:6], rv3[9:8] == 2'b00, rv3[10], rv3[11]);
		end
		table_ready = 1'b1;

		#1 rst_n = 1'b0;
		repeat (5) @(posedge clock_24);
		#1;
		check_val("reset", "controls", 32'hff, 32'({up_n, down_n, left_n, right_n,
			fire_n, coin_n, start1_n, start2_n}));
		check_val("reset", "dip_sw", 32'h0, 32'(dip_sw));
		check_val("reset", "core_rst_n", 32'h0, 32'(core_rst_n));
		check_val("reset", "video", 32'h3, 32'({vga_r, vga_g, vga_b, vga_hs, vga_vs}));
		check_val("reset", "audio_l", 32'h0, 32'(audio_l));
		rst_n = 1'b1;

		foreach (rows[i]) apply_row(rows[i]);

		measure_audio(8'd0);
		measure_audio(8'd64);
		measure_audio(8'd200);
		measure_audio(8'd255);

		$display("Errors: %0d", error_count);
		if (error_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	initial begin
		wait (table_ready);
		repeat (rows.size() * 4 + 4 * 256 + 100) @(posedge clock_24);
		$display("Timeout: the run did not reach its end within the cycle limit");
		$display("Errors: %0d", error_count);
		$display("Some tests failed");
		$finish;
	end

endmodule

// File: sim.f
src/board_cfg_pkg.sv
src/ctrl_pkg.sv
src/key_latch.sv
src/control_mapper.sv
src/video_gate.sv
src/sigma_delta_dac.sv
src/cabinet_io.sv
verif/cabinet_io_assert.sv
verif/tb_cabinet_io.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_cabinet_io
FILELIST   := sim.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Build, run, then search the output for the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
